// ==== cpuCore.f ====
hdl/opcodes.sv
hdl/cpuParams.sv
hdl/alu.sv
hdl/datapath.sv
hdl/control.sv
hdl/cpuCore.sv
tests/cpuCoreTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the cpuCore testbench with Verilator; the log decides pass or fail.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module cpuCoreTb -f cpuCore.f -o cpuCoreSim \
  && ./obj_dir/cpuCoreSim > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "build or simulation did not complete"; exit 1; }

cat sim.log
grep -q "Errors found" sim.log && exit 1 || exit 0

// ==== tests/cpuCoreTb.sv ====
`timescale 1ns/1ns
`default_nettype none

module cpuCoreTb;

  import opcodes::*;

  localparam int     clockPeriod = 40;
  localparam int     numTests    = 8;
  localparam int     maxProgLen  = 32;
  localparam int     memWords    = 256;
  localparam longint watchdogNs  =
    longint'(numTests) * (maxProgLen * 6 * 4 + 30) * clockPeriod;

  logic        Clock;
  logic        reset;
  logic [15:0] dataIn;
  logic        nWait;
  logic [15:0] dataOut;
  logic        ale;
  logic        nOe;
  logic        nMe;
  logic        nWe;
  logic        enb;
  logic        halted;

  logic [15:0] mem [memWords];
  logic [15:0] refMem [memWords];
  logic [31:0] expected [$];
  logic [15:0] busAddr;
  logic [15:0] nextData = '0;
  logic        nextWait = 1'b1;
  logic        firstFetch = 1'b0;
  int          waitLeft = 0;
  int          progLen = 0;
  int          errorCount = 0;
  int          checkCount = 0;
  instrOpcode  aluOps [7] = '{opAdd, opSub, opAnd, opOr, opXor, opShl, opShr};

  cpuCore dut0 (
    .Clock   (Clock  ),
    .reset   (reset  ),
    .dataIn  (dataIn ),
    .nWait   (nWait  ),
    .dataOut (dataOut),
    .ale     (ale    ),
    .nOe     (nOe    ),
    .nMe     (nMe    ),
    .nWe     (nWe    ),
    .enb     (enb    ),
    .halted  (halted )
  );

  initial begin
    Clock = 1'b0;
    forever #(clockPeriod / 2) Clock = ~Clock;
  end

  // ==============================
  // memory model.
  // ==============================
  task automatic checkStore(input logic [15:0] addr, input logic [15:0] data);
    logic [31:0] exp;
    checkCount++;
    mem[addr[7:0]] = data;
    assert (enb) else begin
      $display("** Error at %0t: enb low during store to %h", $time, addr);
      errorCount++;
    end
    assert (expected.size() > 0) else begin
      $display("** Error at %0t: unexpected store of %h to %h", $time, data, addr);
      errorCount++;
    end
    if (expected.size() > 0) begin
      exp = expected.pop_front();
      assert ({addr, data} == exp) else begin
        $display("** Error at %0t: store %h to %h, expected %h to %h",
                 $time, data, addr, exp[15:0], exp[31:16]);
        errorCount++;
      end
    end
  endtask

  // bus outputs are sampled at the falling edge, where they are settled.
  always @(negedge Clock) begin
    if (reset) begin
      nextWait = 1'b1;
      waitLeft = 0;
    end else if (ale) begin
      assert (!firstFetch || dataOut == 16'h0000) else begin
        $display("** Error at %0t: first fetch from %h instead of 0000", $time, dataOut);
        errorCount++;
      end
      firstFetch = 1'b0;
      busAddr    = dataOut;
      waitLeft   = $urandom_range(3, 0);
      nextWait   = (waitLeft == 0);
      nextData   = mem[busAddr[7:0]];
    end else if (!nMe) begin
      // a data cycle is either a read or a write.
      assert ((nOe != nWe) && (enb == !nWe)) else begin
        $display("** Error at %0t: data cycle with nOe %b, nWe %b, enb %b",
                 $time, nOe, nWe, enb);
        errorCount++;
      end
      if (!nWait) begin
        waitLeft--;
        nextWait = (waitLeft == 0);
      end else begin
        if (!nWe) checkStore(busAddr, dataOut);
        nextWait = 1'b1;
      end
    end
  end

  always @(posedge Clock) begin
    #5;
    nWait  = nextWait;
    dataIn = nextData;
  end

  // ==============================
  // program generation.
  // ==============================
  function automatic logic [15:0] encR(input instrOpcode op, input int rd,
                                       input int rs1, input int rs2);
    return {op, 3'(rd), 3'(rs1), 3'(rs2), 3'b000};
  endfunction

  function automatic logic [15:0] encI(input instrOpcode op, input int rd, input int imm);
    return {op, 3'(rd), 9'(imm)};
  endfunction

  function automatic logic [15:0] encM(input instrOpcode op, input int rd,
                                       input int rs1, input int offset);
    return {op, 3'(rd), 3'(rs1), 6'(offset)};
  endfunction

  task automatic emit(input logic [15:0] word);
    mem[progLen] = word;
    progLen++;
  endtask

  task automatic buildProgram(input int kind);
    int   rd;
    logic zeroFirst;
    for (int a = 0; a < memWords; a++) begin
      mem[a] = 16'(a * 40503) ^ 16'hc3a5;
    end
    progLen = 0;
    // r7 is the base of the data area.
    emit(encI(opLdi, 7, 128));
    case (kind)
      0: begin
        for (int k = 0; k < 8; k++) begin
          rd = $urandom_range(6, 0);
          emit(encI(opLdi, rd, $urandom_range(511, 0)));
          emit(encM(opSt, rd, 7, k));
        end
      end
      1: begin
        for (int r = 0; r < 7; r++) begin
          emit(encI(opLdi, r, $urandom_range(511, 0)));
        end
        for (int k = 0; k < 10; k++) begin
          rd = $urandom_range(6, 0);
          emit(encR(aluOps[$urandom_range(6, 0)], rd, $urandom_range(7, 0),
                    $urandom_range(7, 0)));
          emit(encM(opSt, rd, 7, k));
        end
      end
      2: begin
        emit(encI(opLdi, 6, $urandom_range(511, 0)));
        for (int k = 0; k < 6; k++) begin
          rd = $urandom_range(5, 0);
          emit(encM(opLd, rd, 7, k));
          emit(encR(aluOps[$urandom_range(6, 0)], rd, rd, 6));
          emit(encM(opSt, rd, 7, 16 + k));
        end
      end
      default: begin
        zeroFirst = 1'($urandom_range(1, 0));
        emit(encI(opLdi, 1, zeroFirst ? 0 : $urandom_range(255, 1)));
        emit(encI(opBz, 0, 1));
        emit(encM(opSt, 1, 7, 0));
        emit(encI(opLdi, 2, zeroFirst ? $urandom_range(255, 1) : 0));
        emit(encI(opBz, 0, 1));
        emit(encM(opSt, 2, 7, 1));
        // jump over the two stores at 9 and 10.
        emit(encI(opLdi, 3, 11));
        emit(encR(opJmp, 0, 3, 0));
        emit(encM(opSt, 1, 7, 2));
        emit(encM(opSt, 2, 7, 3));
        // routine at 15 sets r5 and returns to 13.
        emit(encI(opLdi, 4, 15));
        emit(encR(opJal, 0, 4, 0));
        emit(encM(opSt, 5, 7, 4));
        emit(encR(opHalt, 0, 0, 0));
        emit(encI(opLdi, 5, $urandom_range(511, 0)));
        emit(encM(opSt, 5, 7, 5));
        emit(encR(opRet, 0, 0, 0));
      end
    endcase
    emit(encR(opHalt, 0, 0, 0));
  endtask

  // ==============================
  // reference model.
  // ==============================
  task automatic runModel();
    logic [15:0] r [8];
    logic [15:0] pc;
    logic [15:0] lr;
    logic [15:0] w;
    logic [15:0] a;
    logic [15:0] b;
    logic [15:0] imm;
    logic [15:0] ea;
    logic [15:0] res;
    logic        wr;
    logic        zf;
    logic        done;
    int          steps;
    pc    = '0;
    lr    = '0;
    res   = '0;
    zf    = 1'b0;
    done  = 1'b0;
    steps = 0;
    for (int i = 0; i < 8; i++) begin
      r[i] = '0;
    end
    expected.delete();
    while (!done && steps < maxProgLen) begin
      w   = refMem[pc[7:0]];
      a   = r[w[8:6]];
      b   = r[w[5:3]];
      imm = {{7{w[8]}}, w[8:0]};
      ea  = a + {{10{w[5]}}, w[5:0]};
      pc  = pc + 16'd1;
      wr  = 1'b1;
      steps++;
      case (instrOpcode'(w[15:12]))
        opAdd:   res = a + b;
        opSub:   res = a - b;
        opAnd:   res = a & b;
        opOr:    res = a | b;
        opXor:   res = a ^ b;
        opShl:   res = a << 1;
        opShr:   res = a >> 1;
        opLdi:   res = imm;
        default: wr = 1'b0;
      endcase
      if (wr) begin
        r[w[11:9]] = res;
        zf = (res == 16'h0000);
      end
      case (instrOpcode'(w[15:12]))
        opLd: r[w[11:9]] = refMem[ea[7:0]];
        opSt: begin
          refMem[ea[7:0]] = r[w[11:9]];
          expected.push_back({ea, r[w[11:9]]});
        end
        opBz:   if (zf) pc = pc + imm;
        opJmp:  pc = a;
        opJal: begin
          lr = pc;
          pc = a;
        end
        opRet:  pc = lr;
        opHalt: done = 1'b1;
        default: ;
      endcase
    end
    if (!done) begin
      $display("reference model ran %0d steps without reaching a halt", steps);
      errorCount++;
    end
  endtask

  // ==============================
  // test sequencing.
  // ==============================
  function automatic string kindName(input int kind);
    case (kind)
      0:       return "load-immediate and store";
      1:       return "alu operations";
      2:       return "loads under wait states";
      default: return "control flow";
    endcase
  endfunction

  task automatic applyReset();
    @(posedge Clock);
    #5;
    reset = 1'b1;
    repeat (3) @(posedge Clock);
    @(negedge Clock);
    checkCount++;
    assert (!ale && nOe && nMe && nWe && !enb && !halted) else begin
      $display("** Error at %0t: bus strobes or halted active during reset", $time);
      errorCount++;
    end
    firstFetch = 1'b1;
    @(posedge Clock);
    #5;
    reset = 1'b0;
  endtask

  task automatic runTest(input int index, input int kind);
    int errorsBefore;
    int storeCount;
    errorsBefore = errorCount;
    buildProgram(kind);
    refMem = mem;
    runModel();
    storeCount = expected.size();
    applyReset();
    while (!halted) @(negedge Clock);
    // the bus must stay quiet once halted.
    repeat (20) begin
      @(negedge Clock);
      checkCount++;
      assert (halted && !ale && nMe) else begin
        $display("** Error at %0t: bus activity or halted low after halt", $time);
        errorCount++;
      end
    end
    checkCount++;
    assert (expected.size() == 0) else begin
      $display("** Error at %0t: %0d expected stores never appeared", $time, expected.size());
      errorCount++;
    end
    $display("test %0d, %s: %0d stores, %0d errors", index, kindName(kind), storeCount,
             errorCount - errorsBefore);
  endtask

  initial begin
    void'($urandom(32'hafd1_b62b));
    reset  = 1'b1;
    dataIn = '0;
    nWait  = 1'b1;
    for (int t = 0; t < numTests; t++) begin
      runTest(t, t % 4);
    end
    $display("tests: %0d, checks: %0d, errors: %0d", numTests, checkCount, errorCount);
    if (errorCount == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

  initial begin
    #(watchdogNs);
    $display("watchdog expired at %0t: the core did not halt", $time);
    $display("Errors found");
    $finish;
  end

endmodule

`default_nettype wire

// ==== hdl/cpuCore.sv ====
`timescale 1ns/1ns
`default_nettype none

module cpuCore (
  input  logic                            Clock,
  input  logic                            reset,
  input  logic [cpuParams::wordWidth-1:0] dataIn,
  input  logic                            nWait,
  output logic [cpuParams::wordWidth-1:0] dataOut,
  output logic                            ale,
  output logic                            nOe,
  output logic                            nMe,
  output logic                            nWe,
  output logic                            enb,
  output logic                            halted
);

  import opcodes::*;
  import cpuParams::*;

  aluFunction           aluOp;
  instrOpcode           opcode;
  logic [flagCount-1:0] flags;
  logic                 aluWe;
  logic                 pcWe;
  logic                 irWe;
  logic                 regWe;
  logic                 lrWe;
  logic                 marWe;
  logic [1:0]           op1Sel;
  logic                 op2Sel;
  logic [1:0]           pcSel;
  logic                 wdSel;
  logic                 immSel;
  logic                 addrSel;
  logic                 dataSel;

  control control0 (
    .Clock   (Clock  ),
    .reset   (reset  ),
    .nWait   (nWait  ),
    .opcode  (opcode ),
    .flags   (flags  ),
    .aluOp   (aluOp  ),
    .aluWe   (aluWe  ),
    .pcWe    (pcWe   ),
    .irWe    (irWe   ),
    .regWe   (regWe  ),
    .lrWe    (lrWe   ),
    .marWe   (marWe  ),
    .op1Sel  (op1Sel ),
    .op2Sel  (op2Sel ),
    .pcSel   (pcSel  ),
    .wdSel   (wdSel  ),
    .immSel  (immSel ),
    .addrSel (addrSel),
    .dataSel (dataSel),
    .ale     (ale    ),
    .nOe     (nOe    ),
    .nMe     (nMe    ),
    .nWe     (nWe    ),
    .enb     (enb    ),
    .halted  (halted )
  );

  datapath datapath0 (
    .Clock   (Clock  ),
    .reset   (reset  ),
    .dataIn  (dataIn ),
    .aluOp   (aluOp  ),
    .aluWe   (aluWe  ),
    .pcWe    (pcWe   ),
    .irWe    (irWe   ),
    .regWe   (regWe  ),
    .lrWe    (lrWe   ),
    .marWe   (marWe  ),
    .op1Sel  (op1Sel ),
    .op2Sel  (op2Sel ),
    .pcSel   (pcSel  ),
    .wdSel   (wdSel  ),
    .immSel  (immSel ),
    .addrSel (addrSel),
    .dataSel (dataSel),
    .dataOut (dataOut),
    .opcode  (opcode ),
    .flags   (flags  )
  );

endmodule

`default_nettype wire

// ==== hdl/control.sv ====
`timescale 1ns/1ns
`default_nettype none

module control (
  input  logic                            Clock,
  input  logic                            reset,
  input  logic                            nWait,
  input  opcodes::instrOpcode             opcode,
  input  logic [cpuParams::flagCount-1:0] flags,
  output opcodes::aluFunction             aluOp,
  output logic                            aluWe,
  output logic                            pcWe,
  output logic                            irWe,
  output logic                            regWe,
  output logic                            lrWe,
  output logic                            marWe,
  output logic [1:0]                      op1Sel,
  output logic                            op2Sel,
  output logic [1:0]                      pcSel,
  output logic                            wdSel,
  output logic                            immSel,
  output logic                            addrSel,
  output logic                            dataSel,
  output logic                            ale,
  output logic                            nOe,
  output logic                            nMe,
  output logic                            nWe,
  output logic                            enb,
  output logic                            halted
);

  import opcodes::*;
  import cpuParams::*;

  controlState state;
  controlState nextState;
  logic        nextRead;
  logic        nextWrite;

  function automatic aluFunction aluFor(input instrOpcode op);
    aluFunction fn;
    case (op)
      opSub:   fn = aluSub;
      opAnd:   fn = aluAnd;
      opOr:    fn = aluOr;
      opXor:   fn = aluXor;
      opShl:   fn = aluShl;
      opShr:   fn = aluShr;
      default: fn = aluAdd;
    endcase
    return fn;
  endfunction

  always_comb begin
    case (state)
      fetchAddr: nextState = fetchData;
      fetchData: nextState = nWait ? decode : fetchData;
      decode:    nextState = execute;
      execute: begin
        if (opcode == opLd || opcode == opSt) nextState = memAddr;
        else if (opcode == opHalt) nextState = halt;
        else nextState = fetchAddr;
      end
      memAddr:   nextState = memData;
      memData:   nextState = nWait ? fetchAddr : memData;
      default:   nextState = halt;
    endcase
  end

  // ==============================
  // datapath enables and selects.
  // ==============================
  always_comb begin
    aluOp   = aluAdd;
    aluWe   = 1'b0;
    pcWe    = 1'b0;
    irWe    = 1'b0;
    regWe   = 1'b0;
    lrWe    = 1'b0;
    marWe   = 1'b0;
    op1Sel  = op1Rs1;
    op2Sel  = op2Reg;
    pcSel   = pcIncrement;
    wdSel   = wbAlu;
    immSel  = immFull;
    addrSel = addrPc;
    dataSel = dataAddress;
    case (state)
      fetchData: begin
        irWe = nWait;
        pcWe = nWait;
      end
      execute: begin
        case (opcode)
          opAdd, opSub, opAnd, opOr, opXor, opShl, opShr: begin
            aluOp = aluFor(opcode);
            aluWe = 1'b1;
            regWe = 1'b1;
          end
          opLdi: begin
            aluOp  = aluPass;
            op2Sel = op2Imm;
            aluWe  = 1'b1;
            regWe  = 1'b1;
          end
          // effective address is rs1 plus the short offset.
          opLd, opSt: begin
            op2Sel = op2Imm;
            immSel = immOffset;
            marWe  = 1'b1;
          end
          opBz: begin
            op1Sel = op1Pc;
            op2Sel = op2Imm;
            pcSel  = pcBranch;
            pcWe   = flags[flagZ];
          end
          opJmp, opJal: begin
            pcSel = pcRegister;
            pcWe  = 1'b1;
            lrWe  = (opcode == opJal);
          end
          opRet: begin
            pcSel = pcLink;
            pcWe  = 1'b1;
          end
          default: ;
        endcase
      end
      memAddr: addrSel = addrMar;
      memData: begin
        addrSel = addrMar;
        if (opcode == opSt) begin
          op1Sel  = op1Rd;
          dataSel = dataStore;
        end else begin
          wdSel = wbMem;
          regWe = nWait;
        end
      end
      default: ;
    endcase
  end

  // strobes are registered from the next state so they line up with it.
  assign nextRead  = (nextState == fetchData) || (nextState == memData && opcode == opLd);
  assign nextWrite = (nextState == memData) && (opcode == opSt);

  always_ff @(posedge Clock) begin
    if (reset) begin
      // ir resets to a nop, so the core leaves reset through execute.
      state  <= execute;
      ale    <= 1'b0;
      nMe    <= 1'b1;
      nOe    <= 1'b1;
      nWe    <= 1'b1;
      enb    <= 1'b0;
      halted <= 1'b0;
    end else begin
      state  <= nextState;
      ale    <= (nextState == fetchAddr) || (nextState == memAddr);
      nMe    <= !(nextState == fetchData || nextState == memData);
      nOe    <= !nextRead;
      nWe    <= !nextWrite;
      enb    <= nextWrite;
      halted <= (nextState == halt);
    end
  end

  assert property (@(posedge Clock) disable iff (reset) !(!nOe && !nWe));
  assert property (@(posedge Clock) disable iff (reset) !(ale && !nMe));
  assert property (@(posedge Clock) disable iff (reset) halted |=> halted);

endmodule

`default_nettype wire

// ==== hdl/datapath.sv ====
`timescale 1ns/1ns
`default_nettype none

module datapath (
  input  logic                            Clock,
  input  logic                            reset,
  input  logic [cpuParams::wordWidth-1:0] dataIn,
  input  opcodes::aluFunction             aluOp,
  input  logic                            aluWe,
  input  logic                            pcWe,
  input  logic                            irWe,
  input  logic                            regWe,
  input  logic                            lrWe,
  input  logic                            marWe,
  input  logic [1:0]                      op1Sel,
  input  logic                            op2Sel,
  input  logic [1:0]                      pcSel,
  input  logic                            wdSel,
  input  logic                            immSel,
  input  logic                            addrSel,
  input  logic                            dataSel,
  output logic [cpuParams::wordWidth-1:0] dataOut,
  output opcodes::instrOpcode             opcode,
  output logic [cpuParams::flagCount-1:0] flags
);

  import opcodes::*;
  import cpuParams::*;

  logic [wordWidth-1:0]    regs [regCount];
  logic [wordWidth-1:0]    pc;
  logic [wordWidth-1:0]    lr;
  logic [wordWidth-1:0]    ir;
  logic [wordWidth-1:0]    mar;
  logic [wordWidth-1:0]    immExt;
  logic [wordWidth-1:0]    op1;
  logic [wordWidth-1:0]    op2;
  logic [wordWidth-1:0]    aluResult;
  logic [wordWidth-1:0]    writeData;
  logic [wordWidth-1:0]    pcNext;
  logic [flagCount-1:0]    aluFlags;
  logic [regAddrWidth-1:0] rdAddr;
  logic [regAddrWidth-1:0] rs1Addr;
  logic [regAddrWidth-1:0] rs2Addr;

  assign opcode  = instrOpcode'(ir[opcodeMsb:opcodeLsb]);
  assign rdAddr  = ir[rdMsb:rdLsb];
  assign rs1Addr = ir[rs1Msb:rs1Lsb];
  assign rs2Addr = ir[rs2Msb:rs2Lsb];

  // ==============================
  // operand and result muxes.
  // ==============================
  assign immExt = (immSel == immOffset) ?
    {{(wordWidth-offsetWidth){ir[offsetWidth-1]}}, ir[offsetWidth-1:0]} :
    {{(wordWidth-immWidth){ir[immWidth-1]}}, ir[immWidth-1:0]};

  always_comb begin
    case (op1Sel)
      op1Rs1:  op1 = regs[rs1Addr];
      op1Rd:   op1 = regs[rdAddr];
      op1Pc:   op1 = pc;
      default: op1 = lr;
    endcase
  end

  assign op2       = (op2Sel == op2Imm) ? immExt : regs[rs2Addr];
  assign writeData = (wdSel == wbMem) ? dataIn : aluResult;

  // pc already points past the current instruction.
  always_comb begin
    case (pcSel)
      pcIncrement: pcNext = pc + 1'b1;
      pcBranch:    pcNext = aluResult;
      pcRegister:  pcNext = op1;
      default:     pcNext = lr;
    endcase
  end

  // address or store data onto the shared bus.
  assign dataOut = (dataSel == dataStore) ? op1 : ((addrSel == addrMar) ? mar : pc);

  alu alu0 (
    .aluOp    (aluOp    ),
    .op1      (op1      ),
    .op2      (op2      ),
    .result   (aluResult),
    .aluFlags (aluFlags )
  );

  // ==============================
  // state registers.
  // ==============================
  always_ff @(posedge Clock) begin
    if (reset) begin
      pc    <= '0;
      flags <= '0;
      ir    <= nopWord;
      for (int i = 0; i < regCount; i++) begin
        regs[i] <= '0;
      end
    end else begin
      if (pcWe) pc <= pcNext;
      if (irWe) ir <= dataIn;
      if (aluWe) flags <= aluFlags;
      if (regWe) regs[rdAddr] <= writeData;
    end
  end

  always_ff @(posedge Clock) begin
    if (lrWe) lr <= pc;
    if (marWe) mar <= aluResult;
  end

  // write-back never overlaps an instruction load.
  assert property (@(posedge Clock) disable iff (reset) regWe |=> $stable(ir));

endmodule

`default_nettype wire

// ==== hdl/alu.sv ====
`timescale 1ns/1ns
`default_nettype none

module alu (
  input  opcodes::aluFunction             aluOp,
  input  logic [cpuParams::wordWidth-1:0] op1,
  input  logic [cpuParams::wordWidth-1:0] op2,
  output logic [cpuParams::wordWidth-1:0] result,
  output logic [cpuParams::flagCount-1:0] aluFlags
);

  import opcodes::*;
  import cpuParams::*;

  logic carry;
  logic overflow;

  always_comb begin
    carry    = 1'b0;
    overflow = 1'b0;
    result   = '0;
    case (aluOp)
      aluAdd: begin
        {carry, result} = {1'b0, op1} + {1'b0, op2};
        overflow = (op1[wordWidth-1] == op2[wordWidth-1]) &&
                   (result[wordWidth-1] != op1[wordWidth-1]);
      end
      aluSub: begin
        // carry doubles as borrow.
        {carry, result} = {1'b0, op1} - {1'b0, op2};
        overflow = (op1[wordWidth-1] != op2[wordWidth-1]) &&
                   (result[wordWidth-1] != op1[wordWidth-1]);
      end
      aluAnd:  result = op1 & op2;
      aluOr:   result = op1 | op2;
      aluXor:  result = op1 ^ op2;
      // shifts take op1 only and the bit shifted out lands in carry.
      aluShl:  {carry, result} = {op1, 1'b0};
      aluShr:  {result, carry} = {1'b0, op1};
      aluPass: result = op2;
    endcase
  end

  assign aluFlags[flagZ] = (result == '0);
  assign aluFlags[flagN] = result[wordWidth-1];
  assign aluFlags[flagC] = carry;
  assign aluFlags[flagV] = overflow;

endmodule

`default_nettype wire

// ==== hdl/cpuParams.sv ====
`default_nettype none

package cpuParams;

  localparam int wordWidth    = 16;
  localparam int regCount     = 8;
  localparam int regAddrWidth = 3;

  // flag register layout.
  localparam int flagCount = 4;
  localparam int flagZ     = 0;
  localparam int flagN     = 1;
  localparam int flagC     = 2;
  localparam int flagV     = 3;

  typedef enum logic [2:0] {
    fetchAddr,
    fetchData,
    decode,
    execute,
    memAddr,
    memData,
    halt
  } controlState;

  // ==============================
  // datapath select encodings.
  // ==============================
  localparam logic [1:0] op1Rs1      = 2'd0;
  localparam logic [1:0] op1Rd       = 2'd1;
  localparam logic [1:0] op1Pc       = 2'd2;
  localparam logic [1:0] op1Lr       = 2'd3;
  localparam logic       op2Reg      = 1'b0;
  localparam logic       op2Imm      = 1'b1;
  localparam logic [1:0] pcIncrement = 2'd0;
  localparam logic [1:0] pcBranch    = 2'd1;
  localparam logic [1:0] pcRegister  = 2'd2;
  localparam logic [1:0] pcLink      = 2'd3;
  localparam logic       wbAlu       = 1'b0;
  localparam logic       wbMem       = 1'b1;
  localparam logic       immFull     = 1'b0;
  localparam logic       immOffset   = 1'b1;
  localparam logic       addrPc      = 1'b0;
  localparam logic       addrMar     = 1'b1;
  localparam logic       dataAddress = 1'b0;
  localparam logic       dataStore   = 1'b1;

endpackage

`default_nettype wire

// ==== hdl/opcodes.sv ====
`default_nettype none

package opcodes;

  // ==============================
  // instruction fields.
  // ==============================
  localparam int instrWidth  = 16;
  localparam int opcodeMsb   = 15;
  localparam int opcodeLsb   = 12;
  localparam int rdMsb       = 11;
  localparam int rdLsb       = 9;
  localparam int rs1Msb      = 8;
  localparam int rs1Lsb      = 6;
  localparam int rs2Msb      = 5;
  localparam int rs2Lsb      = 3;
  // ldi value and bz offset.
  localparam int immWidth    = 9;
  // ld/st address offset added to rs1.
  localparam int offsetWidth = 6;

  typedef enum logic [3:0] {
    opAdd  = 4'h0,
    opSub  = 4'h1,
    opAnd  = 4'h2,
    opOr   = 4'h3,
    opXor  = 4'h4,
    opShl  = 4'h5,
    opShr  = 4'h6,
    opLdi  = 4'h7,
    opLd   = 4'h8,
    opSt   = 4'h9,
    opBz   = 4'ha,
    opJmp  = 4'hb,
    opJal  = 4'hc,
    opRet  = 4'hd,
    opHalt = 4'he,
    opNop  = 4'hf
  } instrOpcode;

  typedef enum logic [2:0] {
    aluAdd,
    aluSub,
    aluAnd,
    aluOr,
    aluXor,
    aluShl,
    aluShr,
    aluPass
  } aluFunction;

  localparam logic [instrWidth-1:0] nopWord = {opNop, 12'h000};

endpackage

`default_nettype wire
